// ==== include/l2_defines.svh ====
// Cache geometry, address widths and operation code values.
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// Line geometry.
`define L2_LINE_BYTES 16
`define L2_LINE_BITS 128

// Set-associative organization.
`define L2_WAYS 4
`define L2_WAY_BITS 2
`define L2_SETS 16
`define L2_SET_BITS 4

// Line address is tag above set index.
`define L2_TAG_BITS 8
`define L2_ADDR_BITS 12

// Hardware strands that may hold a reservation.
`define L2_STRANDS 4
`define L2_STRAND_BITS 2

// Operation codes.
`define L2_OP_LOAD 3'd0
`define L2_OP_STORE 3'd1
`define L2_OP_LOAD_SYNC 3'd2
`define L2_OP_STORE_SYNC 3'd3
`define L2_OP_FILL 3'd4

`endif

// ==== hw/l2_pkg.sv ====
// Operation enumeration and line-address union shared by the cache stages.
`include "l2_defines.svh"

package l2_pkg;

	// Request operation.
	typedef enum logic [2:0]
	{
		OP_LOAD = `L2_OP_LOAD,
		OP_STORE = `L2_OP_STORE,
		OP_LOAD_SYNC = `L2_OP_LOAD_SYNC,
		OP_STORE_SYNC = `L2_OP_STORE_SYNC,
		OP_FILL = `L2_OP_FILL
	} l2_op_e;

	// Line address, either as one word or split into tag and set.
	typedef union packed
	{
		logic [`L2_ADDR_BITS-1:0] line;
		struct packed
		{
			logic [`L2_TAG_BITS-1:0] tag;
			logic [`L2_SET_BITS-1:0] set;
		} f;
	} l2_addr_u;

endpackage

// ==== hw/l2_tag_lookup.sv ====
// Decode stage with tag array, hit detection, round-robin fill way and reservations.
`include "l2_defines.svh"

module l2_tag_lookup (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        req_valid,
	input  l2_pkg::l2_op_e              req_op,
	input  logic [`L2_STRAND_BITS-1:0]  req_strand,
	input  l2_pkg::l2_addr_u            req_addr,
	input  logic [`L2_LINE_BITS-1:0]    req_data,
	input  logic [`L2_LINE_BYTES-1:0]   req_mask,
	output logic                        dc_valid,
	output l2_pkg::l2_op_e              dc_op,
	output logic [`L2_STRAND_BITS-1:0]  dc_strand,
	output l2_pkg::l2_addr_u            dc_addr,
	output logic [`L2_LINE_BITS-1:0]    dc_data,
	output logic [`L2_LINE_BYTES-1:0]   dc_mask,
	output logic                        dc_hit,
	output logic [`L2_WAY_BITS-1:0]     dc_way,
	output logic                        dc_sync_ok,
	output logic                        rd_en,
	output logic [`L2_SET_BITS-1:0]     rd_set,
	output logic [`L2_WAY_BITS-1:0]     rd_way
);
	import l2_pkg::*;

	logic [`L2_TAG_BITS-1:0] tag_q [`L2_SETS][`L2_WAYS];
	logic [`L2_WAYS-1:0] valid_q [`L2_SETS];
	logic [`L2_WAY_BITS-1:0] rr_q [`L2_SETS];
	logic [`L2_ADDR_BITS-1:0] res_line_q [`L2_STRANDS];
	logic [`L2_STRANDS-1:0] res_valid_q;

	logic [`L2_SET_BITS-1:0] set_idx;
	logic [`L2_WAYS-1:0] hit_vec;
	logic [`L2_WAY_BITS-1:0] hit_way;
	logic hit;
	logic is_fill;
	logic fill_req;
	logic sync_ok;
	logic line_written;
	logic res_set;

	assign set_idx = req_addr.f.set;
	assign is_fill = (req_op == OP_FILL);
	assign fill_req = req_valid && is_fill;

	// Compare the full line address against every way of the set.
	always_comb
	begin
		hit_vec = '0;
		hit_way = '0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			hit_vec[w] = valid_q[set_idx][w] &&
				({tag_q[set_idx][w], set_idx} == req_addr.line);
			if (hit_vec[w])
				hit_way = w[`L2_WAY_BITS-1:0];
		end
	end

	assign hit = |hit_vec;

	// Reservation held by this strand on this exact line.
	assign sync_ok = res_valid_q[req_strand] && (res_line_q[req_strand] == req_addr.line);

	// Anything that changes the line drops every reservation on it.
	assign line_written = req_valid && (is_fill ||
		(hit && (req_op == OP_STORE || (req_op == OP_STORE_SYNC && sync_ok))));
	assign res_set = req_valid && hit && (req_op == OP_LOAD_SYNC);

	// Fills take their data from the request, so only hits read the array.
	assign rd_en = req_valid && hit && !is_fill;
	assign rd_set = set_idx;
	assign rd_way = hit_way;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `L2_SETS; s++)
			begin
				valid_q[s] <= '0;
				rr_q[s] <= '0;
			end
			res_valid_q <= '0;
			dc_valid <= 1'b0;
		end
		else
		begin
			dc_valid <= req_valid;
			if (fill_req)
			begin
				valid_q[set_idx][rr_q[set_idx]] <= 1'b1;
				rr_q[set_idx] <= rr_q[set_idx] + {{(`L2_WAY_BITS-1){1'b0}}, 1'b1};
			end
			for (int t = 0; t < `L2_STRANDS; t++)
			begin
				if (line_written && res_line_q[t] == req_addr.line)
					res_valid_q[t] <= 1'b0;
			end
			if (res_set)
				res_valid_q[req_strand] <= 1'b1;
		end
	end

	// Tags, reservation addresses and the stage payload.
	always_ff @(posedge clk)
	begin
		if (fill_req)
			tag_q[set_idx][rr_q[set_idx]] <= req_addr.f.tag;
		if (res_set)
			res_line_q[req_strand] <= req_addr.line;
		dc_op <= req_op;
		dc_strand <= req_strand;
		dc_addr <= req_addr;
		dc_data <= req_data;
		dc_mask <= req_mask;
		dc_hit <= hit || is_fill;
		dc_way <= is_fill ? rr_q[set_idx] : hit_way;
		dc_sync_ok <= sync_ok;
	end

	// A line is never resident in two ways of a set.
	a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> $onehot0(hit_vec));

endmodule

// ==== hw/l2_data_array.sv ====
// Line storage with a registered read port, a write port and write-to-read forwarding.
`include "l2_defines.svh"

module l2_data_array (
	input  logic                      clk,
	input  logic                      rd_en,
	input  logic [`L2_SET_BITS-1:0]   rd_set,
	input  logic [`L2_WAY_BITS-1:0]   rd_way,
	input  logic                      wr_en,
	input  logic [`L2_SET_BITS-1:0]   wr_set,
	input  logic [`L2_WAY_BITS-1:0]   wr_way,
	input  logic [`L2_LINE_BITS-1:0]  wr_line,
	output logic [`L2_LINE_BITS-1:0]  rd_line
);

	// One entry per set and way.
	logic [`L2_LINE_BITS-1:0] mem [`L2_SETS * `L2_WAYS];

	logic [`L2_SET_BITS+`L2_WAY_BITS-1:0] rd_idx;
	logic [`L2_SET_BITS+`L2_WAY_BITS-1:0] wr_idx;
	logic fwd;

	assign rd_idx = {rd_set, rd_way};
	assign wr_idx = {wr_set, wr_way};

	// Same entry written on this edge, so the reader gets the new line.
	assign fwd = wr_en && (wr_idx == rd_idx);

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_idx] <= wr_line;
		if (rd_en)
		begin
			if (fwd)
				rd_line <= wr_line;
			else
				rd_line <= mem[rd_idx];
		end
	end

endmodule

// ==== hw/l2_write_merge.sv ====
// Execute stage with byte-mask merge, old-data select and data-array update decision.
`include "l2_defines.svh"

module l2_write_merge (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        dc_valid,
	input  l2_pkg::l2_op_e              dc_op,
	input  logic [`L2_STRAND_BITS-1:0]  dc_strand,
	input  l2_pkg::l2_addr_u            dc_addr,
	input  logic [`L2_LINE_BITS-1:0]    dc_data,
	input  logic [`L2_LINE_BYTES-1:0]   dc_mask,
	input  logic                        dc_hit,
	input  logic [`L2_WAY_BITS-1:0]     dc_way,
	input  logic                        dc_sync_ok,
	input  logic [`L2_LINE_BITS-1:0]    rd_line,
	output logic                        wr_en,
	output logic [`L2_SET_BITS-1:0]     wr_set,
	output logic [`L2_WAY_BITS-1:0]     wr_way,
	output logic [`L2_LINE_BITS-1:0]    wr_line,
	output logic                        ex_valid,
	output logic [`L2_STRAND_BITS-1:0]  ex_strand,
	output l2_pkg::l2_op_e              ex_op,
	output logic                        ex_hit,
	output logic [`L2_LINE_BITS-1:0]    ex_line,
	output logic                        ex_sync_ok
);
	import l2_pkg::*;

	logic [`L2_LINE_BITS-1:0] old_line;
	logic [`L2_LINE_BITS-1:0] merged_line;
	logic is_store;

	// A fill brings its own line, everything else sees the array.
	assign old_line = (dc_op == OP_FILL) ? dc_data : rd_line;
	assign is_store = (dc_op == OP_STORE) || (dc_op == OP_STORE_SYNC);

	// Store bytes replace old bytes where the mask is set.
	always_comb
	begin
		for (int b = 0; b < `L2_LINE_BYTES; b++)
		begin
			if (dc_mask[b])
				merged_line[b*8 +: 8] = dc_data[b*8 +: 8];
			else
				merged_line[b*8 +: 8] = old_line[b*8 +: 8];
		end
	end

	always_comb
	begin
		wr_en = 1'b0;
		wr_line = merged_line;
		if (dc_valid)
		begin
			case (dc_op)
				// The fill line passes through the merge unchanged.
				OP_FILL:
					wr_en = 1'b1;
				OP_STORE:
					wr_en = dc_hit;
				// Only if no one touched the line since the synchronized load.
				OP_STORE_SYNC:
					wr_en = dc_hit && dc_sync_ok;
				default:
					wr_en = 1'b0;
			endcase
		end
	end

	assign wr_set = dc_addr.f.set;
	assign wr_way = dc_way;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= dc_valid;
	end

	always_ff @(posedge clk)
	begin
		ex_strand <= dc_strand;
		ex_op <= dc_op;
		ex_hit <= dc_hit;
		ex_sync_ok <= dc_sync_ok && dc_hit;
		// Stores report the line as it looks afterwards.
		ex_line <= is_store ? merged_line : old_line;
	end

	// Every write belongs to a live request and carries a fully defined line.
	a_write_has_request: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> dc_valid && !$isunknown({wr_set, wr_way, wr_line}));

endmodule

// ==== hw/l2_response.sv ====
// Result stage that registers the response strobe, line and flags.
`include "l2_defines.svh"

module l2_response (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ex_valid,
	input  logic [`L2_STRAND_BITS-1:0]  ex_strand,
	input  l2_pkg::l2_op_e              ex_op,
	input  logic                        ex_hit,
	input  logic [`L2_LINE_BITS-1:0]    ex_line,
	input  logic                        ex_sync_ok,
	output logic                        resp_valid,
	output logic [`L2_STRAND_BITS-1:0]  resp_strand,
	output l2_pkg::l2_op_e              resp_op,
	output logic                        resp_hit,
	output logic [`L2_LINE_BITS-1:0]    resp_data,
	output logic                        resp_sync_ok
);
	import l2_pkg::*;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else
			resp_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		resp_strand <= ex_strand;
		resp_op <= ex_op;
		resp_hit <= ex_hit;
		// A miss carries no data.
		resp_data <= ex_hit ? ex_line : '0;
		resp_sync_ok <= (ex_op == OP_STORE_SYNC) && ex_sync_ok;
	end

	// Pipeline is empty when reset lifts.
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !resp_valid ##1 !resp_valid);

endmodule

// ==== hw/l2_cache_top.sv ====
// Cache pipeline top level joining decode, data array, execute and result.
`include "l2_defines.svh"

module l2_cache_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        req_valid,
	input  l2_pkg::l2_op_e              req_op,
	input  logic [`L2_STRAND_BITS-1:0]  req_strand,
	input  l2_pkg::l2_addr_u            req_addr,
	input  logic [`L2_LINE_BITS-1:0]    req_data,
	input  logic [`L2_LINE_BYTES-1:0]   req_mask,
	output logic                        resp_valid,
	output logic [`L2_STRAND_BITS-1:0]  resp_strand,
	output l2_pkg::l2_op_e              resp_op,
	output logic                        resp_hit,
	output logic [`L2_LINE_BITS-1:0]    resp_data,
	output logic                        resp_sync_ok
);
	import l2_pkg::*;

	// Decode to execute.
	logic dc_valid;
	l2_op_e dc_op;
	logic [`L2_STRAND_BITS-1:0] dc_strand;
	l2_addr_u dc_addr;
	logic [`L2_LINE_BITS-1:0] dc_data;
	logic [`L2_LINE_BYTES-1:0] dc_mask;
	logic dc_hit;
	logic [`L2_WAY_BITS-1:0] dc_way;
	logic dc_sync_ok;

	// Data array ports.
	logic rd_en;
	logic [`L2_SET_BITS-1:0] rd_set;
	logic [`L2_WAY_BITS-1:0] rd_way;
	logic [`L2_LINE_BITS-1:0] rd_line;
	logic wr_en;
	logic [`L2_SET_BITS-1:0] wr_set;
	logic [`L2_WAY_BITS-1:0] wr_way;
	logic [`L2_LINE_BITS-1:0] wr_line;

	// Execute to result.
	logic ex_valid;
	logic [`L2_STRAND_BITS-1:0] ex_strand;
	l2_op_e ex_op;
	logic ex_hit;
	logic [`L2_LINE_BITS-1:0] ex_line;
	logic ex_sync_ok;

	l2_tag_lookup u_tag_lookup (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_op(req_op), .req_strand(req_strand),
		.req_addr(req_addr), .req_data(req_data), .req_mask(req_mask),
		.dc_valid(dc_valid), .dc_op(dc_op), .dc_strand(dc_strand),
		.dc_addr(dc_addr), .dc_data(dc_data), .dc_mask(dc_mask),
		.dc_hit(dc_hit), .dc_way(dc_way), .dc_sync_ok(dc_sync_ok),
		.rd_en(rd_en), .rd_set(rd_set), .rd_way(rd_way)
	);

	l2_data_array u_data_array (
		.clk(clk),
		.rd_en(rd_en), .rd_set(rd_set), .rd_way(rd_way),
		.wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_line(wr_line),
		.rd_line(rd_line)
	);

	l2_write_merge u_write_merge (
		.clk(clk), .rst_n(rst_n),
		.dc_valid(dc_valid), .dc_op(dc_op), .dc_strand(dc_strand),
		.dc_addr(dc_addr), .dc_data(dc_data), .dc_mask(dc_mask),
		.dc_hit(dc_hit), .dc_way(dc_way), .dc_sync_ok(dc_sync_ok),
		.rd_line(rd_line),
		.wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_line(wr_line),
		.ex_valid(ex_valid), .ex_strand(ex_strand), .ex_op(ex_op),
		.ex_hit(ex_hit), .ex_line(ex_line), .ex_sync_ok(ex_sync_ok)
	);

	l2_response u_response (
		.clk(clk), .rst_n(rst_n),
		.ex_valid(ex_valid), .ex_strand(ex_strand), .ex_op(ex_op),
		.ex_hit(ex_hit), .ex_line(ex_line), .ex_sync_ok(ex_sync_ok),
		.resp_valid(resp_valid), .resp_strand(resp_strand), .resp_op(resp_op),
		.resp_hit(resp_hit), .resp_data(resp_data), .resp_sync_ok(resp_sync_ok)
	);

endmodule

// ==== tb/tb_l2_cache.sv ====
// Directed testbench for the L2 cache pipeline with reference model, LFSR and timeout.
`include "l2_defines.svh"

module tb_l2_cache;
	timeunit 1ns;
	timeprecision 1ps;
	import l2_pkg::*;

	localparam int RESP_LATENCY = 3;
	localparam int NUM_REQUESTS = 51;
	localparam int CYCLE_LIMIT = 4 * NUM_REQUESTS + 50;

	logic clk;
	logic rst_n;
	logic req_valid;
	l2_op_e req_op;
	logic [`L2_STRAND_BITS-1:0] req_strand;
	l2_addr_u req_addr;
	logic [`L2_LINE_BITS-1:0] req_data;
	logic [`L2_LINE_BYTES-1:0] req_mask;
	logic resp_valid;
	logic [`L2_STRAND_BITS-1:0] resp_strand;
	l2_op_e resp_op;
	logic resp_hit;
	logic [`L2_LINE_BITS-1:0] resp_data;
	logic resp_sync_ok;

	int cyc = 0;
	int fail_count = 0;
	logic [15:0] lfsr;

	// Reference copy of tags, victim counters, lines and reservations.
	logic [`L2_TAG_BITS-1:0] m_tag [`L2_SETS][`L2_WAYS];
	logic [`L2_WAYS-1:0] m_valid [`L2_SETS];
	logic [`L2_WAY_BITS-1:0] m_rr [`L2_SETS];
	logic [`L2_LINE_BITS-1:0] m_line [`L2_SETS][`L2_WAYS];
	logic [`L2_ADDR_BITS-1:0] m_res_line [`L2_STRANDS];
	logic [`L2_STRANDS-1:0] m_res_valid;

	// Expected responses in request order.
	int exp_due [$];
	l2_op_e exp_op [$];
	logic [`L2_STRAND_BITS-1:0] exp_strand [$];
	logic exp_hit [$];
	logic [`L2_LINE_BITS-1:0] exp_data [$];
	logic exp_sync [$];

	l2_cache_top UUT (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req_op(req_op), .req_strand(req_strand),
		.req_addr(req_addr), .req_data(req_data), .req_mask(req_mask),
		.resp_valid(resp_valid), .resp_strand(resp_strand), .resp_op(resp_op),
		.resp_hit(resp_hit), .resp_data(resp_data), .resp_sync_ok(resp_sync_ok)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
			$display("Checks failed");
			$fatal(1, "Timeout");
		end
		else
			cyc <= cyc + 1;
	end

	task automatic stop_run();
		fail_count++;
		$display("Checks failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic fail_now(input string msg);
		$display("%s at time %0t", msg, $time);
		stop_run();
	endtask

	task automatic line_equal(input string name, input logic [`L2_LINE_BITS-1:0] want, got);
		if (got !== want)
		begin
			$display("Fail at time %0t: %s expected %h, got %h", $time, name, want, got);
			stop_run();
		end
	endtask

	task automatic flag_equal(input string name, input logic want, got);
		if (got !== want)
		begin
			$display("Fail at time %0t: %s expected %b, got %b", $time, name, want, got);
			stop_run();
		end
	endtask

	task automatic op_equal(input string name, input l2_op_e want, got);
		if (got !== want)
		begin
			$display("Fail at time %0t: %s expected %s, got %s", $time, name, want.name(),
				got.name());
			stop_run();
		end
	endtask

	task automatic strand_equal(input string name, input logic [`L2_STRAND_BITS-1:0] want, got);
		if (got !== want)
		begin
			$display("Fail at time %0t: %s expected %0d, got %0d", $time, name, want, got);
			stop_run();
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_line(output logic [`L2_LINE_BITS-1:0] v);
		for (int i = 0; i < `L2_LINE_BITS; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic rand_mask(output logic [`L2_LINE_BYTES-1:0] v);
		for (int i = 0; i < `L2_LINE_BYTES; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	function automatic l2_addr_u make_addr(input logic [`L2_TAG_BITS-1:0] tag,
		input logic [`L2_SET_BITS-1:0] set);
		l2_addr_u a;
		a.f.tag = tag;
		a.f.set = set;
		return a;
	endfunction

	// Masked bytes come from the store, the rest from the old line.
	function automatic logic [`L2_LINE_BITS-1:0] merge_line(input logic [`L2_LINE_BITS-1:0] old,
		input logic [`L2_LINE_BITS-1:0] data, input logic [`L2_LINE_BYTES-1:0] mask);
		logic [`L2_LINE_BITS-1:0] r;
		r = old;
		for (int b = 0; b < `L2_LINE_BYTES; b++)
			if (mask[b])
				r[b*8 +: 8] = data[b*8 +: 8];
		return r;
	endfunction

	task automatic model_request(input l2_op_e op, input logic [`L2_STRAND_BITS-1:0] strand,
		input l2_addr_u a, input logic [`L2_LINE_BITS-1:0] data,
		input logic [`L2_LINE_BYTES-1:0] mask, output logic hit,
		output logic [`L2_LINE_BITS-1:0] line, output logic sync_ok);
		logic [`L2_SET_BITS-1:0] set;
		logic [`L2_WAY_BITS-1:0] way;
		logic reserved;
		logic written;
		set = a.f.set;
		hit = 1'b0;
		way = '0;
		for (int w = 0; w < `L2_WAYS; w++)
		begin
			if (m_valid[set][w] && m_tag[set][w] == a.f.tag)
			begin
				hit = 1'b1;
				way = w[`L2_WAY_BITS-1:0];
			end
		end
		reserved = m_res_valid[strand] && (m_res_line[strand] == a.line);
		line = '0;
		sync_ok = 1'b0;
		written = 1'b0;
		if (op == OP_FILL)
		begin
			way = m_rr[set];
			m_tag[set][way] = a.f.tag;
			m_valid[set][way] = 1'b1;
			m_rr[set] = m_rr[set] + 1'b1;
			m_line[set][way] = data;
			hit = 1'b1;
			line = data;
			written = 1'b1;
		end
		else if (hit && (op == OP_LOAD || op == OP_LOAD_SYNC))
		begin
			line = m_line[set][way];
			if (op == OP_LOAD_SYNC)
			begin
				m_res_valid[strand] = 1'b1;
				m_res_line[strand] = a.line;
			end
		end
		else if (hit)
		begin
			// A failed synchronized store still reports the merged line.
			line = merge_line(m_line[set][way], data, mask);
			sync_ok = (op == OP_STORE_SYNC) && reserved;
			written = (op == OP_STORE) || reserved;
			if (written)
				m_line[set][way] = line;
		end
		for (int t = 0; t < `L2_STRANDS; t++)
			if (written && m_res_line[t] == a.line)
				m_res_valid[t] = 1'b0;
	endtask

	// Called once per falling edge, before new inputs are driven.
	task automatic collect_response();
		if (resp_valid)
		begin
			if (exp_due.size() == 0)
				fail_now("Response seen with no request outstanding");
			else if (exp_due[0] != cyc)
				fail_now("Response came before its request was 3 cycles old");
			else
			begin
				op_equal("resp_op", exp_op[0], resp_op);
				strand_equal("resp_strand", exp_strand[0], resp_strand);
				flag_equal("resp_hit", exp_hit[0], resp_hit);
				line_equal("resp_data", exp_data[0], resp_data);
				flag_equal("resp_sync_ok", exp_sync[0], resp_sync_ok);
				void'(exp_due.pop_front());
				void'(exp_op.pop_front());
				void'(exp_strand.pop_front());
				void'(exp_hit.pop_front());
				void'(exp_data.pop_front());
				void'(exp_sync.pop_front());
			end
		end
		else if (exp_due.size() != 0 && exp_due[0] <= cyc)
			fail_now("No response 3 cycles after a request");
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		collect_response();
		req_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_due.size() != 0)
			idle_cycle();
	endtask

	task automatic send(input l2_op_e op, input logic [`L2_STRAND_BITS-1:0] strand,
		input l2_addr_u a, input logic [`L2_LINE_BITS-1:0] data,
		input logic [`L2_LINE_BYTES-1:0] mask);
		logic hit;
		logic [`L2_LINE_BITS-1:0] line;
		logic sync_ok;
		@(negedge clk);
		collect_response();
		req_valid = 1'b1;
		req_op = op;
		req_strand = strand;
		req_addr = a;
		req_data = data;
		req_mask = mask;
		model_request(op, strand, a, data, mask, hit, line, sync_ok);
		exp_due.push_back(cyc + RESP_LATENCY);
		exp_op.push_back(op);
		exp_strand.push_back(strand);
		exp_hit.push_back(hit);
		exp_data.push_back(line);
		exp_sync.push_back(sync_ok);
	endtask

	task automatic transact(input l2_op_e op, input logic [`L2_STRAND_BITS-1:0] strand,
		input l2_addr_u a, input logic [`L2_LINE_BITS-1:0] data,
		input logic [`L2_LINE_BYTES-1:0] mask);
		send(op, strand, a, data, mask);
		drain();
	endtask

	// Sets 3 and 9 get four lines each, then set 3 loses its oldest way.
	task automatic fill_then_load();
		logic [`L2_LINE_BITS-1:0] d;
		logic [`L2_SET_BITS-1:0] set;
		logic [`L2_TAG_BITS-1:0] base;
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int s = 0; s < 2; s++)
			begin
				set = (s == 0) ? 4'd3 : 4'd9;
				base = (s == 0) ? 8'h10 : 8'h30;
				for (int w = 0; w < `L2_WAYS; w++)
				begin
					rand_line(d);
					if (pass == 0)
						transact(OP_FILL, 2'd0, make_addr(base + w[7:0], set), d, '0);
					else
						transact(OP_LOAD, 2'd0, make_addr(base + w[7:0], set), '0, '0);
				end
			end
		end
		rand_line(d);
		transact(OP_FILL, 2'd0, make_addr(8'h20, 4'd3), d, '0);
		transact(OP_LOAD, 2'd0, make_addr(8'h10, 4'd3), '0, '0);
		transact(OP_LOAD, 2'd0, make_addr(8'h20, 4'd3), '0, '0);
	endtask

	task automatic store_merge();
		logic [`L2_LINE_BITS-1:0] d;
		logic [`L2_LINE_BYTES-1:0] m;
		rand_line(d);
		rand_mask(m);
		transact(OP_STORE, 2'd1, make_addr(8'h11, 4'd3), d, m);
		transact(OP_LOAD, 2'd1, make_addr(8'h11, 4'd3), '0, '0);
		rand_line(d);
		rand_mask(m);
		transact(OP_STORE, 2'd1, make_addr(8'h55, 4'd3), d, m);
		transact(OP_LOAD, 2'd1, make_addr(8'h55, 4'd3), '0, '0);
		// A miss must leave every way of the set untouched.
		for (int w = 0; w < `L2_WAYS; w++)
			transact(OP_LOAD, 2'd1, make_addr((w == 0) ? 8'h20 : 8'h10 + w[7:0], 4'd3), '0, '0);
	endtask

	task automatic sync_pair();
		logic [`L2_LINE_BITS-1:0] d;
		logic [`L2_LINE_BYTES-1:0] m;
		transact(OP_LOAD_SYNC, 2'd2, make_addr(8'h31, 4'd9), '0, '0);
		for (int i = 0; i < 2; i++)
		begin
			rand_line(d);
			rand_mask(m);
			transact(OP_STORE_SYNC, 2'd2, make_addr(8'h31, 4'd9), d, m);
			transact(OP_LOAD, 2'd2, make_addr(8'h31, 4'd9), '0, '0);
		end
	endtask

	task automatic reservation_loss();
		logic [`L2_LINE_BITS-1:0] d;
		logic [`L2_LINE_BYTES-1:0] m;
		transact(OP_LOAD_SYNC, 2'd0, make_addr(8'h32, 4'd9), '0, '0);
		rand_line(d);
		rand_mask(m);
		transact(OP_STORE, 2'd1, make_addr(8'h32, 4'd9), d, m);
		rand_line(d);
		rand_mask(m);
		transact(OP_STORE_SYNC, 2'd0, make_addr(8'h32, 4'd9), d, m);
		transact(OP_LOAD, 2'd0, make_addr(8'h32, 4'd9), '0, '0);
	endtask

	// One request per cycle into set 5, leaning on forwarding and early tag update.
	task automatic back_to_back();
		logic [`L2_LINE_BITS-1:0] d;
		logic [`L2_LINE_BYTES-1:0] m;
		l2_op_e ops [15];
		logic [`L2_TAG_BITS-1:0] tags [15];
		ops = '{OP_FILL, OP_STORE, OP_LOAD, OP_FILL, OP_LOAD_SYNC, OP_STORE_SYNC, OP_LOAD,
			OP_STORE, OP_FILL, OP_FILL, OP_FILL, OP_LOAD, OP_LOAD, OP_STORE, OP_LOAD};
		tags = '{8'h40, 8'h40, 8'h40, 8'h41, 8'h41, 8'h41, 8'h41, 8'h40, 8'h42, 8'h43,
			8'h44, 8'h40, 8'h44, 8'h41, 8'h41};
		for (int i = 0; i < 15; i++)
		begin
			rand_line(d);
			rand_mask(m);
			send(ops[i], 2'd3, make_addr(tags[i], 4'd5), d, m);
		end
		drain();
	endtask

	initial
	begin
		req_valid = 1'b0;
		req_op = OP_LOAD;
		req_strand = '0;
		req_addr = '0;
		req_data = '0;
		req_mask = '0;
		rst_n = 1'b0;
		lfsr = 16'd30298;
		for (int s = 0; s < `L2_SETS; s++)
		begin
			m_valid[s] = '0;
			m_rr[s] = '0;
		end
		for (int t = 0; t < `L2_STRANDS; t++)
			m_res_line[t] = '0;
		m_res_valid = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		fill_then_load();
		store_merge();
		sync_pair();
		reservation_loss();
		back_to_back();
		// Extra idle cycles catch any stray response.
		repeat (4) idle_cycle();
		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hw/l2_pkg.sv
hw/l2_tag_lookup.sv
hw/l2_data_array.sv
hw/l2_write_merge.sv
hw/l2_response.sv
hw/l2_cache_top.sv
tb/tb_l2_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the L2 cache testbench with Verilator, run it, and judge the run from its log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_l2_cache -o sim_l2

./obj_dir/sim_l2 > sim.log 2>&1 || true
cat sim.log

grep -qx "All checks passed" sim.log
